//--- verilog/mac_pkg.sv
package mac_pkg;

  ////////////////////
  // field widths
  ////////////////////

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [31:0] crc32_t;
  typedef logic [2:0]  frame_kind_t;
  typedef logic [15:0] count_t;

  // ethertypes seen by the parser
  localparam ethertype_t ETH_TYPE_IPV4 = 16'h0800;
  localparam ethertype_t ETH_TYPE_ARP  = 16'h0806;

  localparam mac_addr_t MAC_BROADCAST = 48'hffffffffffff;

  // reflected crc-32, preset to all ones, no final inversion
  localparam crc32_t CRC32_POLY    = 32'hedb88320;
  localparam crc32_t CRC32_RESIDUE = 32'hdebb20e3;

  // shortest legal frame, fcs included
  localparam int unsigned MIN_FRAME_LEN = 64;

  // frame kind codes
  localparam frame_kind_t KIND_OTHER    = 3'd0;
  localparam frame_kind_t KIND_ARP      = 3'd1;
  localparam frame_kind_t KIND_ICMP     = 3'd2;
  localparam frame_kind_t KIND_UDP      = 3'd3;
  localparam frame_kind_t KIND_TCP      = 3'd4;
  localparam frame_kind_t KIND_IP_OTHER = 3'd5;

endpackage

//--- verilog/ip_pkg.sv
package ip_pkg;

  ////////////////////
  // ipv4 fields
  ////////////////////

  typedef logic [31:0] ipv4_t;
  typedef logic [7:0]  ip_proto_t;

  // protocol numbers
  localparam ip_proto_t PROTO_ICMP = 8'd1;
  localparam ip_proto_t PROTO_TCP  = 8'd6;
  localparam ip_proto_t PROTO_UDP  = 8'd17;

  // byte offsets counted from the first byte of the destination mac
  localparam int unsigned IP_PROTO_OFS = 23;
  localparam int unsigned IP_DST_OFS   = 30;

endpackage

//--- verilog/hdr_parser.sv
`timescale 1ns/1ns

module hdr_parser #(
  parameter mac_pkg::mac_addr_t MAC_ADDR  = 48'haadeadbeef01,
  parameter ip_pkg::ipv4_t      IPV4_ADDR = 32'hc0a80101
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           rx_d,
  input  logic                 rx_v,
  output logic                 hdr_done,
  output logic                 addr_ok,
  output logic                 runt,
  output mac_pkg::frame_kind_t kind
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HEADER,
    S_BODY
  } state_t;

  // last header byte we care about
  localparam int unsigned HDR_LAST = ip_pkg::IP_DST_OFS + 3;

  state_t               state;
  logic [15:0]          byte_cnt;
  logic [15:0]          idx;
  logic                 end_q;
  logic                 mac_hit;
  logic                 bc_hit;
  mac_pkg::ethertype_t  eth_type;
  ip_pkg::ip_proto_t    ip_proto;
  ip_pkg::ipv4_t        ip_dst;
  logic [7:0]           mac_byte;
  mac_pkg::frame_kind_t kind_next;
  logic                 addr_next;

  // byte index on rx_d restarts at zero out of idle
  assign idx = (state == S_IDLE) ? 16'd0 : byte_cnt;

  // expected destination byte in wire order
  assign mac_byte = (idx < 16'd6) ? MAC_ADDR[8 * (5 - int'(idx[2:0])) +: 8] : 8'h00;

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      end_q <= 1'b0;
    end else begin
      end_q <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rx_v) begin
            state <= S_HEADER;
          end
        end
        S_HEADER: begin
          if (!rx_v) begin
            state <= S_IDLE;
            end_q <= 1'b1;
          end else if (idx == HDR_LAST) begin
            state <= S_BODY;
          end
        end
        S_BODY: begin
          if (!rx_v) begin
            state <= S_IDLE;
            end_q <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////
  // field capture
  ////////////////////

  always_ff @(posedge clk) begin
    if (rx_v) begin
      // byte count saturates for oversized frames
      if (idx != 16'hffff) begin
        byte_cnt <= idx + 16'd1;
      end
      // fields only come from the header bytes
      if (state != S_BODY) begin
        if (idx == 16'd0) begin
          mac_hit  <= (rx_d == mac_byte);
          bc_hit   <= (rx_d == 8'hff);
          eth_type <= '0;
          ip_proto <= '0;
          ip_dst   <= '0;
        end else if (idx < 16'd6) begin
          mac_hit <= mac_hit & (rx_d == mac_byte);
          bc_hit  <= bc_hit & (rx_d == 8'hff);
        end
        if (idx == 16'd12 || idx == 16'd13) begin
          eth_type <= {eth_type[7:0], rx_d};
        end
        if (idx == ip_pkg::IP_PROTO_OFS) begin
          ip_proto <= rx_d;
        end
        if (idx >= ip_pkg::IP_DST_OFS && idx <= HDR_LAST) begin
          ip_dst <= {ip_dst[23:0], rx_d};
        end
      end
    end
  end

  // classify from the captured fields
  always_comb begin
    kind_next = mac_pkg::KIND_OTHER;
    if (eth_type == mac_pkg::ETH_TYPE_ARP) begin
      kind_next = mac_pkg::KIND_ARP;
    end else if (eth_type == mac_pkg::ETH_TYPE_IPV4) begin
      case (ip_proto)
        ip_pkg::PROTO_ICMP: kind_next = mac_pkg::KIND_ICMP;
        ip_pkg::PROTO_UDP:  kind_next = mac_pkg::KIND_UDP;
        ip_pkg::PROTO_TCP:  kind_next = mac_pkg::KIND_TCP;
        default:            kind_next = mac_pkg::KIND_IP_OTHER;
      endcase
    end
  end

  // ipv4 frames must also carry our address
  assign addr_next = (mac_hit | bc_hit) &
                     ((eth_type != mac_pkg::ETH_TYPE_IPV4) || (ip_dst == IPV4_ADDR));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hdr_done <= 1'b0;
    end else begin
      hdr_done <= end_q;
    end
  end

  // results held until the next frame ends
  always_ff @(posedge clk) begin
    if (end_q) begin
      kind    <= kind_next;
      addr_ok <= addr_next;
      runt    <= (byte_cnt < mac_pkg::MIN_FRAME_LEN);
    end
  end

  a_hdr_done_single : assert property (
    @(posedge clk) disable iff (!rst_n) hdr_done |=> !hdr_done
  );

endmodule

//--- verilog/fcs_checker.sv
`timescale 1ns/1ns

module fcs_checker (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] rx_d,
  input  logic       rx_v,
  output logic       fcs_done,
  output logic       fcs_ok
);

  mac_pkg::crc32_t crc;
  logic            v_q;
  logic            end_q;

  // one byte through the reflected crc, lsb first
  function automatic mac_pkg::crc32_t crc_byte(
    input mac_pkg::crc32_t c,
    input logic [7:0]      d
  );
    mac_pkg::crc32_t r;
    r = c ^ {24'h000000, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ mac_pkg::CRC32_POLY) : (r >> 1);
    end
    return r;
  endfunction

  ////////////////////
  // running crc
  ////////////////////

  // preset on the first byte of a frame
  always_ff @(posedge clk) begin
    if (rx_v) begin
      crc <= crc_byte(v_q ? crc : '1, rx_d);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v_q      <= 1'b0;
      end_q    <= 1'b0;
      fcs_done <= 1'b0;
    end else begin
      v_q      <= rx_v;
      end_q    <= v_q & ~rx_v;
      fcs_done <= end_q;
    end
  end

  // crc is untouched between the end edge and here
  always_ff @(posedge clk) begin
    if (end_q) begin
      fcs_ok <= (crc == mac_pkg::CRC32_RESIDUE);
    end
  end

  // done comes one edge after rx_v dropped
  a_fcs_done_after_end : assert property (
    @(posedge clk) disable iff (!rst_n) fcs_done |-> !$past(rx_v, 2)
  );

endmodule

//--- verilog/frame_judge.sv
`timescale 1ns/1ns

module frame_judge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hdr_done,
  input  logic                 addr_ok,
  input  logic                 runt,
  input  mac_pkg::frame_kind_t kind,
  input  logic                 fcs_done,
  input  logic                 fcs_ok,
  output logic                 frame_done,
  output logic                 frame_ok,
  output mac_pkg::frame_kind_t frame_kind,
  output mac_pkg::count_t      good_count,
  output mac_pkg::count_t      error_count,
  output mac_pkg::count_t      filtered_count
);

  logic is_err;
  logic is_filt;
  logic is_good;

  // holds at the top value
  function automatic mac_pkg::count_t sat_inc(input mac_pkg::count_t c);
    return (c == '1) ? c : c + 16'd1;
  endfunction

  ////////////////////
  // decision
  ////////////////////

  // bad fcs or short frame wins over addressing
  assign is_err  = ~fcs_ok | runt;
  assign is_filt = ~is_err & ~addr_ok;
  assign is_good = ~is_err & addr_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_done <= 1'b0;
      frame_ok   <= 1'b0;
    end else begin
      frame_done <= hdr_done;
      if (hdr_done) begin
        frame_ok <= is_good;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_done) begin
      frame_kind <= kind;
    end
  end

  ////////////////////
  // statistics
  ////////////////////

  // exactly one counter moves per frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      good_count     <= '0;
      error_count    <= '0;
      filtered_count <= '0;
    end else if (hdr_done) begin
      if (is_err) begin
        error_count <= sat_inc(error_count);
      end
      if (is_filt) begin
        filtered_count <= sat_inc(filtered_count);
      end
      if (is_good) begin
        good_count <= sat_inc(good_count);
      end
    end
  end

  // parser and crc checker finish on the same edge
  a_done_aligned : assert property (
    @(posedge clk) disable iff (!rst_n) hdr_done == fcs_done
  );

endmodule

//--- verilog/eth_rx.sv
`timescale 1ns/1ns

module eth_rx #(
  parameter mac_pkg::mac_addr_t MAC_ADDR  = 48'haadeadbeef01,
  parameter ip_pkg::ipv4_t      IPV4_ADDR = 32'hc0a80101
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           rx_d,
  input  logic                 rx_v,
  output logic                 frame_done,
  output logic                 frame_ok,
  output mac_pkg::frame_kind_t frame_kind,
  output mac_pkg::count_t      good_count,
  output mac_pkg::count_t      error_count,
  output mac_pkg::count_t      filtered_count
);

  logic                 hdr_done;
  logic                 addr_ok;
  logic                 runt;
  mac_pkg::frame_kind_t kind;
  logic                 fcs_done;
  logic                 fcs_ok;

  // header fields and crc run side by side on the same bytes
  hdr_parser #(
    .MAC_ADDR  (MAC_ADDR),
    .IPV4_ADDR (IPV4_ADDR)
  ) hdr_parser_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_d     (rx_d),
    .rx_v     (rx_v),
    .hdr_done (hdr_done),
    .addr_ok  (addr_ok),
    .runt     (runt),
    .kind     (kind)
  );

  fcs_checker fcs_checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_d     (rx_d),
    .rx_v     (rx_v),
    .fcs_done (fcs_done),
    .fcs_ok   (fcs_ok)
  );

  frame_judge frame_judge_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_done       (hdr_done),
    .addr_ok        (addr_ok),
    .runt           (runt),
    .kind           (kind),
    .fcs_done       (fcs_done),
    .fcs_ok         (fcs_ok),
    .frame_done     (frame_done),
    .frame_ok       (frame_ok),
    .frame_kind     (frame_kind),
    .good_count     (good_count),
    .error_count    (error_count),
    .filtered_count (filtered_count)
  );

endmodule

//--- bench/eth_model.svh
`ifndef ETH_MODEL_SVH
`define ETH_MODEL_SVH

////////////////////
// random numbers
////////////////////

logic [31:0] lfsr_q = 32'd20;

// taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
  lfsr_q = {lfsr_q[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

function automatic int rand_range(input int lo, input int hi);
  return lo + int'(rand_bits(16) % (hi - lo + 1));
endfunction

////////////////////
// frame builder
////////////////////

logic [7:0] frm [0:255];
int         frm_len;
bit         frm_bad;

// bitwise reflected crc over the first n bytes of frm
function automatic mac_pkg::crc32_t crc_bytes(input int n);
  mac_pkg::crc32_t c;
  logic            fb;
  c = '1;
  for (int i = 0; i < n; i++) begin
    for (int b = 0; b < 8; b++) begin
      fb = c[0] ^ frm[i][b];
      c = c >> 1;
      if (fb) begin
        c = c ^ mac_pkg::CRC32_POLY;
      end
    end
  end
  return c;
endfunction

// ftype 0 unknown, 1 arp, 2 icmp, 3 udp, 4 tcp, 5 other ip
// amode 0 ours, 1 broadcast, 2 wrong mac, 3 wrong ip
task automatic build_frame(input int ftype, input int amode, input int len, input bit bad);
  mac_pkg::mac_addr_t  dst;
  mac_pkg::ethertype_t etype;
  ip_pkg::ipv4_t       ip;
  mac_pkg::crc32_t     fcs;
  int                  pos;
  frm_len = len;
  frm_bad = bad;
  for (int i = 0; i < len - 4; i++) begin
    frm[i] = 8'(rand_bits(8));
  end
  dst = (amode == 1) ? mac_pkg::MAC_BROADCAST : MAC_ADDR;
  // lsb of the flip is set, so never ours and never broadcast
  if (amode == 2) begin
    dst = dst ^ ((48'(rand_bits(32)) << 16) | 48'(rand_bits(16)) | 48'd1);
  end
  ip = IPV4_ADDR;
  if (amode == 3) begin
    ip = ip ^ (rand_bits(32) | 32'd1);
  end
  case (ftype)
    0:       etype = 16'h8600 | 16'(rand_bits(8));
    1:       etype = mac_pkg::ETH_TYPE_ARP;
    default: etype = mac_pkg::ETH_TYPE_IPV4;
  endcase
  for (int i = 0; i < 6; i++) begin
    frm[i] = dst[8 * (5 - i) +: 8];
  end
  frm[12] = etype[15:8];
  frm[13] = etype[7:0];
  frm[14] = 8'h45;
  case (ftype)
    2: frm[ip_pkg::IP_PROTO_OFS] = ip_pkg::PROTO_ICMP;
    3: frm[ip_pkg::IP_PROTO_OFS] = ip_pkg::PROTO_UDP;
    4: frm[ip_pkg::IP_PROTO_OFS] = ip_pkg::PROTO_TCP;
    5: frm[ip_pkg::IP_PROTO_OFS] = 8'h80 | 8'(rand_bits(7));
    default: ;
  endcase
  for (int i = 0; i < 4; i++) begin
    frm[ip_pkg::IP_DST_OFS + i] = ip[8 * (3 - i) +: 8];
  end
  // fcs goes out inverted, low byte first
  fcs = ~crc_bytes(len - 4);
  for (int i = 0; i < 4; i++) begin
    frm[len - 4 + i] = fcs[8 * i +: 8];
  end
  if (bad) begin
    pos = rand_range(0, len - 1);
    frm[pos] = frm[pos] ^ (8'(rand_bits(8)) | 8'h01);
  end
endtask

////////////////////
// reference decision
////////////////////

task automatic expect_frame(input int done_cyc);
  mac_pkg::mac_addr_t   dst;
  mac_pkg::ethertype_t  etype;
  ip_pkg::ipv4_t        ip;
  mac_pkg::frame_kind_t k;
  bit                   addr_ok;
  bit                   err;
  for (int i = 0; i < 6; i++) begin
    dst[8 * (5 - i) +: 8] = frm[i];
  end
  for (int i = 0; i < 4; i++) begin
    ip[8 * (3 - i) +: 8] = frm[ip_pkg::IP_DST_OFS + i];
  end
  etype = {frm[12], frm[13]};
  k = mac_pkg::KIND_OTHER;
  if (etype == mac_pkg::ETH_TYPE_ARP) begin
    k = mac_pkg::KIND_ARP;
  end else if (etype == mac_pkg::ETH_TYPE_IPV4) begin
    case (frm[ip_pkg::IP_PROTO_OFS])
      ip_pkg::PROTO_ICMP: k = mac_pkg::KIND_ICMP;
      ip_pkg::PROTO_UDP:  k = mac_pkg::KIND_UDP;
      ip_pkg::PROTO_TCP:  k = mac_pkg::KIND_TCP;
      default:            k = mac_pkg::KIND_IP_OTHER;
    endcase
  end
  addr_ok = (dst == MAC_ADDR || dst == mac_pkg::MAC_BROADCAST) &&
            (etype != mac_pkg::ETH_TYPE_IPV4 || ip == IPV4_ADDR);
  err = frm_bad || (frm_len < mac_pkg::MIN_FRAME_LEN);
  if (err) begin
    exp_err++;
  end else if (!addr_ok) begin
    exp_filt++;
  end else begin
    exp_good++;
  end
  ok_q.push_back(!err && addr_ok);
  kind_q.push_back(k);
  cyc_q.push_back(done_cyc);
endtask

`endif

//--- bench/tb_eth_rx.sv
`timescale 1ns/1ns

module tb;

  localparam mac_pkg::mac_addr_t MAC_ADDR  = 48'haadeadbeef01;
  localparam ip_pkg::ipv4_t      IPV4_ADDR = 32'hc0a80101;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_LEN      = 127;
  localparam int MAX_GAP      = 8;
  localparam int MIX_FRAMES   = 200;
  // 12 good, 12 corrupted, 12 addressing, 8 runt, 10 back to back, then the mix
  localparam int NUM_FRAMES   = 54 + MIX_FRAMES;

  logic                 clk;
  logic                 rst_n;
  logic [7:0]           rx_d;
  logic                 rx_v;
  logic                 frame_done;
  logic                 frame_ok;
  mac_pkg::frame_kind_t frame_kind;
  mac_pkg::count_t      good_count;
  mac_pkg::count_t      error_count;
  mac_pkg::count_t      filtered_count;

  int cyc = 0;
  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int exp_good = 0;
  int exp_err = 0;
  int exp_filt = 0;

  // expected results, one entry per frame in flight
  bit                   ok_q [$];
  mac_pkg::frame_kind_t kind_q [$];
  int                   cyc_q [$];

  `include "eth_model.svh"

  eth_rx #(
    .MAC_ADDR  (MAC_ADDR),
    .IPV4_ADDR (IPV4_ADDR)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_d           (rx_d),
    .rx_v           (rx_v),
    .frame_done     (frame_done),
    .frame_ok       (frame_ok),
    .frame_kind     (frame_kind),
    .good_count     (good_count),
    .error_count    (error_count),
    .filtered_count (filtered_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////
  // output monitor
  ////////////////////

  always @(negedge clk) begin
    if (frame_done) begin
      if (cyc_q.size() == 0) begin
        $display("frame_done pulsed at cycle %0d with no frame outstanding", cyc);
        errors++;
      end else begin
        if (cyc != cyc_q[0]) begin
          $display("frame_done came at cycle %0d instead of cycle %0d", cyc, cyc_q[0]);
          errors++;
        end
        if (frame_ok !== ok_q[0]) begin
          $display("FAILED frame_ok: expected %h, got %h", ok_q[0], frame_ok);
          errors++;
        end
        if (frame_kind !== kind_q[0]) begin
          $display("FAILED frame_kind: expected %h, got %h", kind_q[0], frame_kind);
          errors++;
        end
        void'(ok_q.pop_front());
        void'(kind_q.pop_front());
        void'(cyc_q.pop_front());
      end
    end else if (cyc_q.size() != 0 && cyc >= cyc_q[0]) begin
      $display("no frame_done for the frame due at cycle %0d", cyc_q[0]);
      errors++;
      void'(ok_q.pop_front());
      void'(kind_q.pop_front());
      void'(cyc_q.pop_front());
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // gap is the number of idle cycles before the next frame
  task automatic send_frame(input int gap);
    for (int i = 0; i < frm_len; i++) begin
      @(posedge clk);
      rx_d <= frm[i];
      rx_v <= 1'b1;
    end
    @(posedge clk);
    rx_d <= 8'h00;
    rx_v <= 1'b0;
    // end edge is next, done shows three edges later
    expect_frame(cyc + 4);
    repeat (gap - 1) @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    while (cyc_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    if (good_count !== 16'(exp_good)) begin
      $display("FAILED good_count: expected %h, got %h", 16'(exp_good), good_count);
      errors++;
    end
    if (error_count !== 16'(exp_err)) begin
      $display("FAILED error_count: expected %h, got %h", 16'(exp_err), error_count);
      errors++;
    end
    if (filtered_count !== 16'(exp_filt)) begin
      $display("FAILED filtered_count: expected %h, got %h", 16'(exp_filt), filtered_count);
      errors++;
    end
    if (errors == err_before) begin
      tests_ok++;
      $display("%-14s ok", name);
    end else begin
      tests_bad++;
      $display("%-14s FAIL, %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int e0;
    rst_n = 1'b0;
    rx_d  = 8'h00;
    rx_v  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      build_frame(i % 6, 0, rand_range(64, MAX_LEN), 1'b0);
      send_frame(rand_range(1, MAX_GAP));
    end
    finish_test("good frames", e0);

    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      build_frame(rand_range(0, 5), 0, rand_range(64, MAX_LEN), 1'b1);
      send_frame(rand_range(1, MAX_GAP));
    end
    finish_test("corrupted", e0);

    // broadcast, wrong mac, wrong ip on ipv4 frames
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      build_frame(2 + i % 4, 1 + i % 3, rand_range(64, MAX_LEN), 1'b0);
      send_frame(rand_range(1, MAX_GAP));
    end
    finish_test("addressing", e0);

    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      build_frame(rand_range(0, 5), 0, rand_range(40, 63), 1'b0);
      send_frame(rand_range(1, MAX_GAP));
    end
    finish_test("runt frames", e0);

    e0 = errors;
    for (int i = 0; i < 10; i++) begin
      build_frame(rand_range(0, 5), rand_range(0, 3), rand_range(40, MAX_LEN),
                  rand_bits(3) == 0);
      send_frame(1);
    end
    finish_test("back to back", e0);

    e0 = errors;
    for (int i = 0; i < MIX_FRAMES; i++) begin
      build_frame(rand_range(0, 5), rand_range(0, 3), rand_range(40, MAX_LEN),
                  rand_bits(3) == 0);
      send_frame(rand_range(1, 4));
    end
    finish_test("random mix", e0);

    $display("tests ok: %0d, tests failing: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // longest frame plus longest gap plus pipeline, for every frame
  initial begin
    repeat (RESET_CYCLES + NUM_FRAMES * (MAX_LEN + MAX_GAP + 4)) @(posedge clk);
    $display("watchdog expired before all frames were checked");
    $display("test failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+bench
verilog/mac_pkg.sv
verilog/ip_pkg.sv
verilog/hdr_parser.sv
verilog/fcs_checker.sv
verilog/frame_judge.sv
verilog/eth_rx.sv
bench/tb_eth_rx.sv
